/* bench/clock_gen.sv */
`default_nettype none

module clock_gen (
	output logic clk,
	output logic reset
);

	localparam int HALF_PERIOD = 4;
	localparam int RESET_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// release on a falling edge so the first clean edge is well defined
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* bench/vga_text_tb.sv */
`default_nettype none

module vga_text_tb;

	localparam int FRAME_CYCLES = vga_pkg::H_TOTAL * vga_pkg::V_TOTAL;
	// frame 0 runs while loading, then two checked frames and one spare
	localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES;
	localparam int NUM_GLYPHS = 16;
	localparam int NUM_REWRITES = 20;
	localparam int FRAME_PIXELS = vga_pkg::H_VISIBLE * vga_pkg::V_VISIBLE;

	logic clk;
	logic reset;
	vga_pkg::char_wr_t char_wr;
	vga_pkg::font_wr_t font_wr;
	vga_pkg::rgb_t fg;
	vga_pkg::rgb_t bg;
	logic vga_hsync;
	logic vga_vsync;
	logic vga_blank_n;
	vga_pkg::rgb_t vga_rgb;

	// copies of what the DUT memories should hold
	vga_pkg::char_code_t text_model [vga_pkg::TEXT_ROWS][vga_pkg::TEXT_COLS];
	vga_pkg::glyph_bits_t font_model [vga_pkg::FONT_GLYPHS][vga_pkg::GLYPH_H];
	vga_pkg::char_code_t glyph_codes [NUM_GLYPHS];
	vga_pkg::rgb_t fg_model;
	vga_pkg::rgb_t bg_model;

	bit loaded = 1'b0;
	bit checking = 1'b0;
	int frames_checked = 0;
	int cycle_count = 0;

	// checker state tracked from the output ports only
	bit prev_hsync = 1'b1;
	bit prev_vsync = 1'b1;
	bit prev_blank_n = 1'b0;
	bit seen_hfall = 1'b0;
	bit seen_vfall = 1'b0;
	bit seen_vrise = 1'b0;
	int h_gap = 0;
	int h_low = 0;
	int v_gap = 0;
	int v_low = 0;
	int run_len = 0;
	int line_count = 0;
	int pix_count = 0;

	clock_gen clock_gen0 (
		.clk(clk),
		.reset(reset)
	);

	vga_text_top dut0 (
		.clk(clk),
		.reset(reset),
		.char_wr(char_wr),
		.font_wr(font_wr),
		.fg(fg),
		.bg(bg),
		.vga_hsync(vga_hsync),
		.vga_vsync(vga_vsync),
		.vga_blank_n(vga_blank_n),
		.vga_rgb(vga_rgb)
	);

	task automatic stop_on_error();
		$display("test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// expected colour of visible pixel (x, y) from the model arrays
	function automatic vga_pkg::rgb_t expected_rgb(input int x, input int y,
		input vga_pkg::rgb_t fg_c, input vga_pkg::rgb_t bg_c);
		vga_pkg::col_t col;
		vga_pkg::row_t row;
		vga_pkg::glyph_line_t line;
		vga_pkg::pixel_sel_t sel;
		vga_pkg::char_code_t code;
		vga_pkg::glyph_bits_t glyph;
		col = vga_pkg::col_t'(x / vga_pkg::GLYPH_W);
		row = vga_pkg::row_t'(y / vga_pkg::GLYPH_H);
		line = vga_pkg::glyph_line_t'(y % vga_pkg::GLYPH_H);
		sel = vga_pkg::pixel_sel_t'(x % vga_pkg::GLYPH_W);
		code = text_model[row][col];
		glyph = font_model[code][line];
		// leftmost pixel sits in bit 7
		if (glyph[3'd7 - sel]) begin
			return fg_c;
		end
		return bg_c;
	endfunction

	task automatic write_cell(input vga_pkg::col_t col, input vga_pkg::row_t row,
		input vga_pkg::char_code_t code);
		@(negedge clk);
		font_wr.en = 1'b0;
		char_wr = '{en: 1'b1, col: col, row: row, code: code};
		text_model[row][col] = code;
	endtask

	task automatic write_glyph_line(input vga_pkg::char_code_t code,
		input vga_pkg::glyph_line_t line, input vga_pkg::glyph_bits_t bits);
		@(negedge clk);
		char_wr.en = 1'b0;
		font_wr = '{en: 1'b1, code: code, line: line, bits: bits};
		font_model[code][line] = bits;
	endtask

	task automatic release_write_ports();
		@(negedge clk);
		char_wr.en = 1'b0;
		font_wr.en = 1'b0;
	endtask

	task automatic load_font();
		for (int g = 0; g < NUM_GLYPHS; g++) begin
			// one code from each block of 16 keeps the set distinct
			glyph_codes[4'(g)] = vga_pkg::char_code_t'(g * 16 + int'($urandom % 16));
			for (int l = 0; l < vga_pkg::GLYPH_H; l++) begin
				write_glyph_line(glyph_codes[4'(g)], vga_pkg::glyph_line_t'(l),
					vga_pkg::glyph_bits_t'($urandom));
			end
		end
	endtask

	task automatic load_text();
		for (int r = 0; r < vga_pkg::TEXT_ROWS; r++) begin
			for (int c = 0; c < vga_pkg::TEXT_COLS; c++) begin
				write_cell(vga_pkg::col_t'(c), vga_pkg::row_t'(r),
					glyph_codes[4'($urandom % NUM_GLYPHS)]);
			end
		end
	endtask

	task automatic rewrite_during_blank();
		for (int i = 0; i < NUM_REWRITES; i++) begin
			write_cell(vga_pkg::col_t'($urandom % vga_pkg::TEXT_COLS),
				vga_pkg::row_t'($urandom % vga_pkg::TEXT_ROWS),
				glyph_codes[4'($urandom % NUM_GLYPHS)]);
		end
		for (int i = 0; i < 2; i++) begin
			write_glyph_line(glyph_codes[4'($urandom % NUM_GLYPHS)],
				vga_pkg::glyph_line_t'($urandom), vga_pkg::glyph_bits_t'($urandom));
		end
		release_write_ports();
		fg = vga_pkg::rgb_t'(24'($urandom));
		bg = vga_pkg::rgb_t'(24'($urandom));
		fg_model = fg;
		bg_model = bg;
	endtask

	initial begin
		void'($urandom(32'h1378_c4bc));
		char_wr = '0;
		font_wr = '0;
		fg = 24'hf0_f0_f0;
		bg = 24'h10_20_40;
		fg_model = fg;
		bg_model = bg;
		wait (!reset);
		load_font();
		load_text();
		release_write_ports();
		loaded = 1'b1;
		wait (frames_checked == 1);
		// the checker has just seen the last pixel, so this is vertical blank
		rewrite_during_blank();
		wait (frames_checked == 2);
		$display("test passed");
		$finish;
	end

	always @(negedge clk) begin
		vga_pkg::rgb_t exp_rgb;
		if (!reset) begin
			if (!vga_blank_n) begin
				assert (vga_rgb == '0) else begin
					$display("ERR %0t vga_rgb in blank expected %06h got %06h",
						$time, 24'h0, vga_rgb);
					stop_on_error();
				end
			end

			if (prev_hsync && !vga_hsync) begin
				if (seen_hfall) begin
					assert (h_gap == vga_pkg::H_TOTAL) else begin
						$display("ERR %0t vga_hsync period expected %0d got %0d",
							$time, vga_pkg::H_TOTAL, h_gap);
						stop_on_error();
					end
				end
				seen_hfall = 1'b1;
				h_gap = 0;
			end
			if (!prev_hsync && vga_hsync) begin
				assert (h_low == vga_pkg::H_SYNC) else begin
					$display("ERR %0t vga_hsync low width expected %0d got %0d",
						$time, vga_pkg::H_SYNC, h_low);
					stop_on_error();
				end
				h_low = 0;
			end

			// vertical timing counted in clocks
			if (prev_vsync && !vga_vsync) begin
				if (seen_vfall) begin
					assert (v_gap == FRAME_CYCLES) else begin
						$display("ERR %0t vga_vsync period expected %0d got %0d",
							$time, FRAME_CYCLES, v_gap);
						stop_on_error();
					end
				end
				if (seen_vrise) begin
					assert (line_count == vga_pkg::V_VISIBLE) else begin
						$display("ERR %0t active lines expected %0d got %0d",
							$time, vga_pkg::V_VISIBLE, line_count);
						stop_on_error();
					end
				end
				seen_vfall = 1'b1;
				v_gap = 0;
			end
			if (!prev_vsync && vga_vsync) begin
				assert (v_low == vga_pkg::V_SYNC * vga_pkg::H_TOTAL) else begin
					$display("ERR %0t vga_vsync low width expected %0d got %0d",
						$time, vga_pkg::V_SYNC * vga_pkg::H_TOTAL, v_low);
					stop_on_error();
				end
				v_low = 0;
				seen_vrise = 1'b1;
				line_count = 0;
				pix_count = 0;
				checking = loaded;
			end

			if (prev_blank_n && !vga_blank_n) begin
				assert (run_len == vga_pkg::H_VISIBLE) else begin
					$display("ERR %0t vga_blank_n high run expected %0d got %0d",
						$time, vga_pkg::H_VISIBLE, run_len);
					stop_on_error();
				end
				run_len = 0;
				line_count++;
			end

			if (vga_blank_n) begin
				if (checking) begin
					exp_rgb = expected_rgb(pix_count % vga_pkg::H_VISIBLE,
						pix_count / vga_pkg::H_VISIBLE, fg_model, bg_model);
					assert (vga_rgb == exp_rgb) else begin
						$display("ERR %0t vga_rgb at (%0d,%0d) expected %06h got %06h",
							$time, pix_count % vga_pkg::H_VISIBLE,
							pix_count / vga_pkg::H_VISIBLE, exp_rgb, vga_rgb);
						stop_on_error();
					end
				end
				run_len++;
				pix_count++;
				if (checking && pix_count == FRAME_PIXELS) begin
					checking = 1'b0;
					frames_checked++;
				end
			end

			if (!vga_hsync) begin
				h_low++;
			end
			if (!vga_vsync) begin
				v_low++;
			end
			h_gap++;
			v_gap++;
			prev_hsync = vga_hsync;
			prev_vsync = vga_vsync;
			prev_blank_n = vga_blank_n;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles before both frames were checked",
				cycle_count);
			stop_on_error();
		end
	end

endmodule

`default_nettype wire

/* list.f */
src/vga_pkg.sv
src/vga_sync.sv
src/text_buffer.sv
src/font_ram.sv
src/text_renderer.sv
src/vga_text_top.sv
bench/clock_gen.sv
bench/vga_text_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the VGA text display testbench with Verilator.

set -u
cd "$(dirname "$0")" || exit 1

TOP=vga_text_tb
BUILD_DIR=obj_dir
SIM_BIN=vga_text_sim
LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module "$TOP" \
	--Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* src/font_ram.sv */
`default_nettype none

module font_ram (
	input wire logic clk,
	input wire vga_pkg::font_wr_t font_wr,
	input wire vga_pkg::char_code_t rd_code,
	input wire vga_pkg::glyph_line_t rd_line,
	output vga_pkg::glyph_bits_t bits
);

	vga_pkg::glyph_bits_t mem [vga_pkg::FONT_DEPTH];
	vga_pkg::font_addr_t wr_addr;
	vga_pkg::font_addr_t rd_addr;

	// 16 lines per glyph, code in the upper bits
	assign wr_addr = {font_wr.code, font_wr.line};
	assign rd_addr = {rd_code, rd_line};

	always_ff @(posedge clk) begin
		if (font_wr.en) begin
			mem[wr_addr] <= font_wr.bits;
		end
	end

	always_ff @(posedge clk) begin
		bits <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* src/text_buffer.sv */
`default_nettype none

module text_buffer (
	input wire logic clk,
	input wire vga_pkg::char_wr_t char_wr,
	input wire vga_pkg::col_t rd_col,
	input wire vga_pkg::row_t rd_row,
	output vga_pkg::char_code_t code
);

	vga_pkg::char_code_t mem [vga_pkg::TEXT_CELLS];
	vga_pkg::cell_addr_t wr_addr;
	vga_pkg::cell_addr_t rd_addr;

	// row major, 80 cells per row
	assign wr_addr = vga_pkg::cell_addr_t'(char_wr.row)
		* vga_pkg::cell_addr_t'(vga_pkg::TEXT_COLS)
		+ vga_pkg::cell_addr_t'(char_wr.col);
	assign rd_addr = vga_pkg::cell_addr_t'(rd_row)
		* vga_pkg::cell_addr_t'(vga_pkg::TEXT_COLS)
		+ vga_pkg::cell_addr_t'(rd_col);

	always_ff @(posedge clk) begin
		if (char_wr.en) begin
			mem[wr_addr] <= char_wr.code;
		end
	end

	// read sees the old word on a same-cycle write
	always_ff @(posedge clk) begin
		code <= mem[rd_addr];
	end

	// host must stay inside the 80x30 grid
	write_in_grid: assert property (@(posedge clk)
		char_wr.en |-> (char_wr.col < vga_pkg::col_t'(vga_pkg::TEXT_COLS))
			&& (char_wr.row < vga_pkg::row_t'(vga_pkg::TEXT_ROWS)));

endmodule

`default_nettype wire

/* src/text_renderer.sv */
`default_nettype none

module text_renderer (
	input wire logic clk,
	input wire logic reset,
	input wire vga_pkg::vga_pos_t pos,
	input wire vga_pkg::char_wr_t char_wr,
	input wire vga_pkg::font_wr_t font_wr,
	input wire vga_pkg::rgb_t fg,
	input wire vga_pkg::rgb_t bg,
	output logic hsync,
	output logic vsync,
	output logic blank_n,
	output vga_pkg::rgb_t rgb
);

	// per-pixel control that rides along with the memory reads
	typedef struct packed {
		vga_pkg::pixel_sel_t pixel_sel;
		logic valid;
		logic hsync;
		logic vsync;
	} ctl_t;

	vga_pkg::col_t rd_col;
	vga_pkg::row_t rd_row;
	vga_pkg::glyph_line_t line_in;
	ctl_t ctl_in;

	ctl_t s1_ctl;
	vga_pkg::glyph_line_t s1_line;
	vga_pkg::char_code_t s1_code;

	ctl_t s2_ctl;
	vga_pkg::glyph_bits_t s2_bits;
	logic pixel;

	// outside the visible area read cell 0 so the address stays in range
	assign rd_col = pos.valid
		? vga_pkg::col_t'(pos.h_addr / vga_pkg::h_addr_t'(vga_pkg::GLYPH_W)) : '0;
	assign rd_row = pos.valid
		? vga_pkg::row_t'(pos.v_addr / vga_pkg::v_addr_t'(vga_pkg::GLYPH_H)) : '0;
	assign line_in = vga_pkg::glyph_line_t'(pos.v_addr % vga_pkg::v_addr_t'(vga_pkg::GLYPH_H));

	assign ctl_in.pixel_sel =
		vga_pkg::pixel_sel_t'(pos.h_addr % vga_pkg::h_addr_t'(vga_pkg::GLYPH_W));
	assign ctl_in.valid = pos.valid;
	assign ctl_in.hsync = pos.hsync;
	assign ctl_in.vsync = pos.vsync;

	// stage 1 looks up the character
	text_buffer text_buffer0 (
		.clk(clk),
		.char_wr(char_wr),
		.rd_col(rd_col),
		.rd_row(rd_row),
		.code(s1_code)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_ctl <= '{pixel_sel: '0, valid: 1'b0, hsync: 1'b1, vsync: 1'b1};
		end else begin
			s1_ctl <= ctl_in;
		end
	end

	always_ff @(posedge clk) begin
		s1_line <= line_in;
	end

	// stage 2 looks up the glyph line
	font_ram font_ram0 (
		.clk(clk),
		.font_wr(font_wr),
		.rd_code(s1_code),
		.rd_line(s1_line),
		.bits(s2_bits)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			s2_ctl <= '{pixel_sel: '0, valid: 1'b0, hsync: 1'b1, vsync: 1'b1};
		end else begin
			s2_ctl <= s1_ctl;
		end
	end

	// stage 3 picks the pixel and the colour
	assign pixel = s2_bits[3'd7 - s2_ctl.pixel_sel];

	always_ff @(posedge clk) begin
		if (reset) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			blank_n <= 1'b0;
			rgb <= '0;
		end else begin
			hsync <= s2_ctl.hsync;
			vsync <= s2_ctl.vsync;
			blank_n <= s2_ctl.valid;
			if (!s2_ctl.valid) begin
				rgb <= '0;
			end else if (pixel) begin
				rgb <= fg;
			end else begin
				rgb <= bg;
			end
		end
	end

	blank_is_black: assert property (@(posedge clk) disable iff (reset)
		!blank_n |-> (rgb == '0));

endmodule

`default_nettype wire

/* src/vga_pkg.sv */
`default_nettype none

package vga_pkg;

	// horizontal timing in pixels
	localparam int H_VISIBLE = 640;
	localparam int H_FRONT = 16;
	localparam int H_SYNC = 96;
	localparam int H_BACK = 48;
	localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

	// vertical timing in lines
	localparam int V_VISIBLE = 480;
	localparam int V_FRONT = 10;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 33;
	localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

	// sync pulse windows, start inclusive, end exclusive
	localparam int H_SYNC_START = H_VISIBLE + H_FRONT;
	localparam int H_SYNC_END = H_SYNC_START + H_SYNC;
	localparam int V_SYNC_START = V_VISIBLE + V_FRONT;
	localparam int V_SYNC_END = V_SYNC_START + V_SYNC;

	// text grid
	localparam int TEXT_COLS = 80;
	localparam int TEXT_ROWS = 30;
	localparam int GLYPH_W = 8;
	localparam int GLYPH_H = 16;
	localparam int TEXT_CELLS = TEXT_COLS * TEXT_ROWS;
	localparam int FONT_GLYPHS = 256;
	localparam int FONT_DEPTH = FONT_GLYPHS * GLYPH_H;

	typedef logic [9:0] h_addr_t;
	typedef logic [9:0] v_addr_t;
	typedef logic [6:0] col_t;
	typedef logic [4:0] row_t;
	typedef logic [7:0] char_code_t;
	typedef logic [3:0] glyph_line_t;
	// bit 7 is the leftmost pixel
	typedef logic [7:0] glyph_bits_t;
	typedef logic [2:0] pixel_sel_t;
	typedef logic [11:0] cell_addr_t;
	typedef logic [11:0] font_addr_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// sync levels are active low
	typedef struct packed {
		h_addr_t h_addr;
		v_addr_t v_addr;
		logic valid;
		logic hsync;
		logic vsync;
	} vga_pos_t;

	typedef struct packed {
		logic en;
		col_t col;
		row_t row;
		char_code_t code;
	} char_wr_t;

	typedef struct packed {
		logic en;
		char_code_t code;
		glyph_line_t line;
		glyph_bits_t bits;
	} font_wr_t;

endpackage

`default_nettype wire

/* src/vga_sync.sv */
`default_nettype none

module vga_sync (
	input wire logic clk,
	input wire logic reset,
	output vga_pkg::vga_pos_t pos
);

	vga_pkg::h_addr_t h_cnt;
	vga_pkg::h_addr_t h_next;
	vga_pkg::v_addr_t v_cnt;
	vga_pkg::v_addr_t v_next;
	logic h_wrap;
	logic v_wrap;
	logic valid_q;
	logic hsync_q;
	logic vsync_q;

	assign h_wrap = (h_cnt == vga_pkg::h_addr_t'(vga_pkg::H_TOTAL - 1));
	assign v_wrap = (v_cnt == vga_pkg::v_addr_t'(vga_pkg::V_TOTAL - 1));

	always_comb begin
		h_next = h_wrap ? '0 : h_cnt + 10'd1;
		v_next = v_cnt;
		// vertical steps once per line
		if (h_wrap) begin
			v_next = v_wrap ? '0 : v_cnt + 10'd1;
		end
	end

	// flags decoded from the next count so they line up with the position
	always_ff @(posedge clk) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
			valid_q <= 1'b1;
			hsync_q <= 1'b1;
			vsync_q <= 1'b1;
		end else begin
			h_cnt <= h_next;
			v_cnt <= v_next;
			valid_q <= (h_next < vga_pkg::h_addr_t'(vga_pkg::H_VISIBLE))
				&& (v_next < vga_pkg::v_addr_t'(vga_pkg::V_VISIBLE));
			hsync_q <= !((h_next >= vga_pkg::h_addr_t'(vga_pkg::H_SYNC_START))
				&& (h_next < vga_pkg::h_addr_t'(vga_pkg::H_SYNC_END)));
			vsync_q <= !((v_next >= vga_pkg::v_addr_t'(vga_pkg::V_SYNC_START))
				&& (v_next < vga_pkg::v_addr_t'(vga_pkg::V_SYNC_END)));
		end
	end

	assign pos.h_addr = h_cnt;
	assign pos.v_addr = v_cnt;
	assign pos.valid = valid_q;
	assign pos.hsync = hsync_q;
	assign pos.vsync = vsync_q;

	counters_in_range: assert property (@(posedge clk) disable iff (reset)
		(h_cnt < vga_pkg::h_addr_t'(vga_pkg::H_TOTAL))
		&& (v_cnt < vga_pkg::v_addr_t'(vga_pkg::V_TOTAL)));

endmodule

`default_nettype wire

/* src/vga_text_top.sv */
`default_nettype none

module vga_text_top (
	input wire logic clk,
	input wire logic reset,
	input wire vga_pkg::char_wr_t char_wr,
	input wire vga_pkg::font_wr_t font_wr,
	input wire vga_pkg::rgb_t fg,
	input wire vga_pkg::rgb_t bg,
	output wire logic vga_hsync,
	output wire logic vga_vsync,
	output wire logic vga_blank_n,
	output wire vga_pkg::rgb_t vga_rgb
);

	vga_pkg::vga_pos_t pos;

	vga_sync vga_sync0 (
		.clk(clk),
		.reset(reset),
		.pos(pos)
	);

	// outputs lag the counters by the renderer's three stages
	text_renderer text_renderer0 (
		.clk(clk),
		.reset(reset),
		.pos(pos),
		.char_wr(char_wr),
		.font_wr(font_wr),
		.fg(fg),
		.bg(bg),
		.hsync(vga_hsync),
		.vsync(vga_vsync),
		.blank_n(vga_blank_n),
		.rgb(vga_rgb)
	);

endmodule

`default_nettype wire
